// ==== rtl/bus_pkg.sv ====
// widths, sizes, bus phase enum
// status and write request structs
package bus_pkg;

	// host bus is 7 bits, one word per address
	localparam int bus_width = 7;
	localparam int ram_depth = 2 ** bus_width; // 128 words, full address space

	// core reset stretch after reset50 drops
	localparam int por_cycles = 8;

	typedef logic [bus_width-1:0] bus_word_t; // data word
	typedef logic [bus_width-1:0] bus_addr_t; // memory address

	// bus state machine phases
	// one phase per winning strobe, idle when nothing is up
	typedef enum logic [1:0] {
		phase_idle  = 2'd0,
		phase_addr  = 2'd1, // ale won
		phase_write = 2'd2, // write won
		phase_read  = 2'd3  // read won
	} bus_phase_e;

	// status bits as they go to the leds, msb first
	typedef struct packed {
		logic ack;        // ale or write taken last edge
		logic valid;      // read word on read_data
		logic read_mode;
		logic write_mode;
		logic ale_mode;
	} bus_status_t;

	// write request toward the memory
	// addr doubles as the read address
	typedef struct packed {
		logic      en;
		bus_addr_t addr;
		bus_word_t data;
	} ram_write_t;

endpackage

// ==== rtl/por_timer.sv ====
// power-on timer
// stretches reset50 into the core reset
`timescale 1ns/1ps

module por_timer
	import bus_pkg::*;
(
	input  logic clock50,
	input  logic reset50,
	output logic core_reset
);

	logic [3:0] count; // big enough for por_cycles

	// restart on reset50, count only while core held
	always_ff @(posedge clock50) begin
		if (reset50) begin
			core_reset <= 1'b1;
			count <= '0;
		end else if (core_reset) begin
			count <= count + 4'd1;
			// release on the edge the count reaches por_cycles
			if (count == 4'(por_cycles - 1)) begin
				core_reset <= 1'b0;
			end
		end
	end

	// once released the core stays out of reset
	// until the host pulls reset50 again
	a_reset_source: assert property (
		@(posedge clock50)
		$rose(core_reset) |-> $past(reset50)
	) else $error("core reset rose without reset50");

	// hold length seen from the outside
	a_hold_length: assert property (
		@(posedge clock50)
		$fell(reset50) |-> core_reset [*por_cycles]
	) else $error("core reset released early");

endmodule

// ==== rtl/bus_cycle_fsm.sv ====
// bus cycle state machine
// strobe priority, address and data latch, read capture, ack and valid
`timescale 1ns/1ps

module bus_cycle_fsm
	import bus_pkg::*;
(
	input  logic        clock50,
	input  logic        core_reset,
	input  bus_word_t   bus_in,
	input  logic        ale,
	input  logic        write,
	input  logic        read,
	input  bus_word_t   rd_word,   // registered memory output
	output ram_write_t  ram_wr,
	output bus_addr_t   rd_addr,
	output bus_word_t   read_data,
	output bus_status_t status
);

	bus_phase_e phase;      // phase taken at the last edge
	bus_phase_e phase_next; // strobe winning this cycle
	ram_write_t wr_q;       // address reg, data reg, write enable
	bus_word_t  read_q;     // word handed back to the host
	logic       ack_q;
	logic       valid_q;

	// only one strobe per cycle
	// ale over write over read
	always_comb begin
		phase_next = phase_idle;
		if (ale) begin
			phase_next = phase_addr;
		end else if (write) begin
			phase_next = phase_write;
		end else if (read) begin
			phase_next = phase_read;
		end
	end

	// state follows the winner, back to idle with no strobe
	always_ff @(posedge clock50) begin
		if (core_reset) begin
			phase <= phase_idle; // strobes ignored while held
		end else begin
			phase <= phase_next;
		end
	end

	// address and write data registers
	// enable is high for the cycle after a sampled write
	always_ff @(posedge clock50) begin
		if (core_reset) begin
			wr_q <= '0;
		end else begin
			wr_q.en <= (phase_next == phase_write);
			if (phase_next == phase_addr) begin
				wr_q.addr <= bus_in; // address phase
			end
			if (phase_next == phase_write) begin
				wr_q.data <= bus_in; // stored one edge later
			end
		end
	end

	// pulses and read capture
	// a strobe held for n cycles gives n pulses
	always_ff @(posedge clock50) begin
		if (core_reset) begin
			ack_q <= 1'b0;
			valid_q <= 1'b0;
			read_q <= '0;
		end else begin
			ack_q <= (phase_next == phase_addr) || (phase_next == phase_write);
			valid_q <= (phase_next == phase_read);
			if (phase_next == phase_read) begin
				read_q <= rd_word; // memory output from the edge before
			end
		end
	end

	assign ram_wr = wr_q;
	assign rd_addr = wr_q.addr; // memory reads the latched address every edge
	assign read_data = read_q;

	// status levels straight from the phase
	always_comb begin
		status.ack = ack_q;
		status.valid = valid_q;
		status.read_mode = (phase == phase_read);
		status.write_mode = (phase == phase_write);
		status.ale_mode = (phase == phase_addr);
	end

	// one answer per strobe
	a_ack_valid_excl: assert property (
		@(posedge clock50) disable iff (core_reset)
		!(status.ack && status.valid)
	) else $error("ack and valid high together");

	// write request only after a write that beat ale
	a_write_phase: assert property (
		@(posedge clock50) disable iff (core_reset)
		ram_wr.en |-> (phase == phase_write) && $past(write && !ale)
	) else $error("write enable outside write phase");

endmodule

// ==== rtl/register_ram.sv ====
// register memory, 128 words of 7 bits
// one write port, registered read port
`timescale 1ns/1ps

module register_ram
	import bus_pkg::*;
(
	input  logic       clock50,
	input  logic       core_reset,
	input  ram_write_t ram_wr,
	input  bus_addr_t  rd_addr,
	output bus_word_t  rd_word
);

	// contents survive reset, only the read reg clears
	bus_word_t mem [ram_depth];

	// write port
	always_ff @(posedge clock50) begin
		if (ram_wr.en) begin
			mem[ram_wr.addr] <= ram_wr.data;
		end
	end

	// read port, read before write on the same address
	// so a fresh word shows up one edge after the store
	always_ff @(posedge clock50) begin
		if (core_reset) begin
			rd_word <= '0;
		end else begin
			rd_word <= mem[rd_addr];
		end
	end

	// an unknown address would corrupt an unknown word
	a_wr_addr_known: assert property (
		@(posedge clock50) disable iff (core_reset)
		ram_wr.en |-> !$isunknown(ram_wr.addr)
	) else $error("write with unknown address");

endmodule

// ==== rtl/bus_memory_top.sv ====
// bus memory top: power-on timer, bus state machine, memory
// led status vector
`timescale 1ns/1ps

module bus_memory_top
	import bus_pkg::*;
(
	input  logic       clock50,
	input  logic       reset50,
	input  bus_word_t  bus_in,
	input  logic       ale,
	input  logic       write,
	input  logic       read,
	output bus_word_t  read_data,
	output logic       ack,
	output logic       valid,
	output logic [7:0] leds
);

	logic        core_reset; // stretched reset for fsm and memory
	ram_write_t  ram_wr;
	bus_addr_t   rd_addr;
	bus_word_t   rd_word;
	bus_status_t status;

	por_timer por_i (
		.clock50    (clock50),
		.reset50    (reset50),
		.core_reset (core_reset)
	);

	bus_cycle_fsm fsm_i (
		.clock50    (clock50),
		.core_reset (core_reset),
		.bus_in     (bus_in),
		.ale        (ale),
		.write      (write),
		.read       (read),
		.rd_word    (rd_word),
		.ram_wr     (ram_wr),
		.rd_addr    (rd_addr),
		.read_data  (read_data),
		.status     (status)
	);

	register_ram ram_i (
		.clock50    (clock50),
		.core_reset (core_reset),
		.ram_wr     (ram_wr),
		.rd_addr    (rd_addr),
		.rd_word    (rd_word)
	);

	assign ack = status.ack;
	assign valid = status.valid;

	// 7 ack, 6 valid, 5..3 read/write/ale mode, 0 core reset
	assign leds = {status.ack, status.valid, status.read_mode, status.write_mode,
		status.ale_mode, 2'b00, core_reset};

endmodule

// ==== verif/bus_memory_checker.sv ====
// per-cycle model of ack, valid and the mode leds, read word compare
// pulse counts per test, wait loops with timeouts, closing count line
`timescale 1ns/1ps

module bus_memory_checker
	import bus_pkg::*;
(
	input logic       clock50,
	input logic       ale,
	input logic       write,
	input logic       read,
	input bus_word_t  read_data,
	input logic       ack,
	input logic       valid,
	input logic [7:0] leds
);

	bus_word_t expected_q [$];     // words the next valid pulses must carry
	logic      have_exp = 1'b0;    // no prediction before the first negedge
	logic      exp_ack;
	logic      exp_valid;
	logic [2:0] exp_mode;          // read, write, ale as on leds 5..3
	int        ack_count = 0;
	int        valid_count = 0;
	int        error_count = 0;
	int        test_errors = 0;    // error_count when the test began
	int        test_count = 0;
	int        pass_count = 0;
	string     test_name = "";

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERR %s exp 0x%0h got 0x%0h", name, exp, got);
			error_count++;
		end
	endtask

	// outputs settle after the posedge, so look at them on the negedge
	always @(negedge clock50) begin
		bus_word_t want;
		// first edge sees core reset still unknown, pulses count from the next one
		if (have_exp) begin
			compare("ack", ack, exp_ack);
			compare("valid", valid, exp_valid);
			compare("leds", leds[7:1], {exp_ack, exp_valid, exp_mode, 2'b00});
			if (ack === 1'b1) begin
				ack_count++;
			end
			if (valid === 1'b1) begin
				valid_count++;
				if (expected_q.size() == 0) begin
					$display("valid pulse came with no read word expected");
					error_count++;
				end else begin
					want = expected_q.pop_front();
					compare("read_data", read_data, want);
				end
			end
		end
		// prediction for the edge ahead, core reset as that edge sees it
		have_exp = 1'b1;
		exp_ack = 1'b0;
		exp_valid = 1'b0;
		exp_mode = 3'b000;
		if (leds[0] !== 1'b0) begin
			exp_mode = 3'b000; // held core ignores strobes
		end else if (ale) begin
			exp_ack = 1'b1;
			exp_mode = 3'b001;
		end else if (write) begin
			exp_ack = 1'b1;
			exp_mode = 3'b010;
		end else if (read) begin
			exp_valid = 1'b1;
			exp_mode = 3'b100;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		ack_count = 0;
		valid_count = 0;
		test_errors = error_count;
	endtask

	task automatic expect_word(input bus_word_t w);
		expected_q.push_back(w);
	endtask

	// counts move on negedges, read them on posedges
	task automatic wait_counts(input int acks, input int valids, input int max_cycles);
		int waited;
		waited = 0;
		while ((ack_count < acks || valid_count < valids) && waited < max_cycles) begin
			@(posedge clock50);
			waited++;
		end
		if (ack_count < acks || valid_count < valids) begin
			$display("timeout in %s: only %0d ack and %0d valid pulses after %0d cycles",
				test_name, ack_count, valid_count, max_cycles);
			error_count++;
		end
	endtask

	// leds read on the posedge, before the edge moves them
	task automatic wait_release(input int max_cycles);
		int   waited;
		logic released;
		waited = 0;
		released = 1'b0;
		while (!released && waited < max_cycles) begin
			@(posedge clock50);
			waited++;
			released = (leds[0] === 1'b0);
		end
		if (!released) begin
			$display("timeout: core reset still high %0d cycles after the strobes dropped",
				max_cycles);
			error_count++;
		end
	endtask

	task automatic end_test(input int acks, input int valids);
		int errs;
		compare("ack_count", 8'(ack_count), 8'(acks));
		compare("valid_count", 8'(valid_count), 8'(valids));
		if (expected_q.size() != 0) begin
			$display("%0d expected read words never came back", expected_q.size());
			error_count++;
			expected_q.delete();
		end
		errs = error_count - test_errors;
		test_count++;
		if (errs == 0) begin
			pass_count++;
			$display("test %0d %s: ok", test_count, test_name);
		end else begin
			$display("test %0d %s: %0d errors", test_count, test_name, errs);
		end
	endtask

	task automatic report();
		$display("tests %0d, ok %0d, errors %0d", test_count, pass_count, error_count);
	endtask

endmodule

// ==== verif/bus_memory_tb.sv ====
// testbench: clock, reset, stimulus table, LFSR random phase
// drives bus_memory_top, the checker instance does the comparing
`timescale 1ns/1ps

module bus_memory_tb
	import bus_pkg::*;
();

	localparam logic [31:0] lfsr_seed = 32'h5a02_f595;
	localparam int row_count = 17;
	localparam int random_pairs = 20;
	localparam int strobe_hold = 4;    // strobes stay up this long after reset50 drops
	localparam int valid_timeout = 10; // cycles

	// one table row, strobes as {ale, write, read}
	typedef struct packed {
		logic [2:0] strobes;
		bus_word_t  value;   // bus_in while the strobes are up
		logic [1:0] cycles;  // hold length, n cycles give n pulses
		bus_word_t  word;    // expected read word
		logic [1:0] acks;
		logic [1:0] valids;
	} table_row_t;

	logic       clock50;
	logic       reset50;
	logic       ale;
	logic       write;
	logic       read;
	bus_word_t  bus_in;
	bus_word_t  read_data;
	logic       ack;
	logic       valid;
	logic [7:0] leds;

	table_row_t rows [row_count];
	string      row_names [row_count];
	int         row_fill = 0;
	logic [31:0] lfsr_state;
	bus_word_t  shadow [ram_depth];       // last random word per address
	bus_addr_t  rnd_addr [random_pairs];

	initial begin
		clock50 = 1'b0;
		forever #50 clock50 = ~clock50; // 100 ns period
	end

	bus_memory_top dut_i (
		.clock50   (clock50),
		.reset50   (reset50),
		.bus_in    (bus_in),
		.ale       (ale),
		.write     (write),
		.read      (read),
		.read_data (read_data),
		.ack       (ack),
		.valid     (valid),
		.leds      (leds)
	);

	bus_memory_checker checker_i (
		.clock50   (clock50),
		.ale       (ale),
		.write     (write),
		.read      (read),
		.read_data (read_data),
		.ack       (ack),
		.valid     (valid),
		.leds      (leds)
	);

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(input int n, output bus_word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[bus_width-2:0], lfsr_state[0]};
		end
	endtask

	task automatic add_row(input string name, input logic [2:0] strobes, input bus_word_t value,
		input int cycles, input bus_word_t word, input int acks, input int valids);
		rows[row_fill].strobes = strobes;
		rows[row_fill].value = value;
		rows[row_fill].cycles = 2'(cycles);
		rows[row_fill].word = word;
		rows[row_fill].acks = 2'(acks);
		rows[row_fill].valids = 2'(valids);
		row_names[row_fill] = name;
		row_fill++;
	endtask

	// strobes for n edges, then two idle edges
	task automatic drive_row(input logic [2:0] strobes, input bus_word_t value, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clock50);
			ale <= strobes[2];
			write <= strobes[1];
			read <= strobes[0];
			bus_in <= value;
		end
		repeat (2) begin
			@(posedge clock50);
			ale <= 1'b0;
			write <= 1'b0;
			read <= 1'b0;
		end
	endtask

	initial begin
		bus_addr_t addr;
		bus_word_t word;
		reset50 = 1'b1;
		ale = 1'b1; // strobes up during the hold, must be ignored
		write = 1'b1;
		read = 1'b1;
		bus_in = 7'h7f;
		lfsr_state = lfsr_seed;

		add_row("ale 15", 3'b100, 7'h15, 1, 7'h00, 1, 0);
		add_row("write 2a", 3'b010, 7'h2a, 1, 7'h00, 1, 0);
		add_row("read 15", 3'b001, 7'h00, 1, 7'h2a, 0, 1);
		add_row("ale 40", 3'b100, 7'h40, 1, 7'h00, 1, 0);
		add_row("write 11 held", 3'b010, 7'h11, 2, 7'h00, 2, 0);
		add_row("ale 15 again", 3'b100, 7'h15, 1, 7'h00, 1, 0);
		add_row("read 15 again", 3'b001, 7'h00, 1, 7'h2a, 0, 1);
		add_row("ale 40 again", 3'b100, 7'h40, 1, 7'h00, 1, 0);
		add_row("read 40 held", 3'b001, 7'h00, 3, 7'h11, 0, 3);
		add_row("ale 33", 3'b100, 7'h33, 1, 7'h00, 1, 0);
		add_row("write 5c", 3'b010, 7'h5c, 1, 7'h00, 1, 0);
		add_row("ale over write", 3'b110, 7'h15, 1, 7'h00, 1, 0);
		add_row("read new address", 3'b001, 7'h00, 1, 7'h2a, 0, 1); // only address moved
		add_row("ale 33 again", 3'b100, 7'h33, 1, 7'h00, 1, 0);
		add_row("read 33 untouched", 3'b001, 7'h00, 1, 7'h5c, 0, 1);
		add_row("write over read", 3'b011, 7'h0f, 1, 7'h00, 1, 0); // no valid
		add_row("read 0f", 3'b001, 7'h00, 1, 7'h0f, 0, 1);

		// reset hold with strobes up
		checker_i.start_test("reset hold");
		repeat (3) @(posedge clock50);
		reset50 <= 1'b0;
		repeat (strobe_hold) @(posedge clock50);
		ale <= 1'b0;
		write <= 1'b0;
		read <= 1'b0;
		checker_i.wait_release(por_cycles + 4 - strobe_hold);
		checker_i.end_test(0, 0);

		for (int r = 0; r < row_count; r++) begin
			checker_i.start_test(row_names[r]);
			repeat (rows[r].valids) checker_i.expect_word(rows[r].word);
			drive_row(rows[r].strobes, rows[r].value, rows[r].cycles);
			checker_i.wait_counts(rows[r].acks, rows[r].valids, valid_timeout);
			checker_i.end_test(rows[r].acks, rows[r].valids);
		end

		// random addresses and words, repeats keep the last word
		checker_i.start_test("random write");
		for (int i = 0; i < random_pairs; i++) begin
			take_bits(bus_width, addr);
			take_bits(bus_width, word);
			rnd_addr[i] = addr;
			shadow[addr] = word;
			drive_row(3'b100, addr, 1);
			drive_row(3'b010, word, 1);
		end
		checker_i.wait_counts(2 * random_pairs, 0, valid_timeout);
		checker_i.end_test(2 * random_pairs, 0);

		checker_i.start_test("random read back");
		for (int i = 0; i < random_pairs; i++) begin
			drive_row(3'b100, rnd_addr[i], 1);
			checker_i.expect_word(shadow[rnd_addr[i]]);
			drive_row(3'b001, 7'h00, 1);
			checker_i.wait_counts(i + 1, i + 1, valid_timeout); // one ale, one read per pair
		end
		checker_i.end_test(random_pairs, random_pairs);

		checker_i.report();
		if (checker_i.error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== bus_memory.f ====
rtl/bus_pkg.sv
rtl/por_timer.sv
rtl/bus_cycle_fsm.sv
rtl/register_ram.sv
rtl/bus_memory_top.sv
verif/bus_memory_checker.sv
verif/bus_memory_tb.sv

// ==== Bender.yml ====
package:
  name: bus_memory

sources:
  - files:
      - rtl/bus_pkg.sv
      - rtl/por_timer.sv
      - rtl/bus_cycle_fsm.sv
      - rtl/register_ram.sv
      - rtl/bus_memory_top.sv
  - target: test
    files:
      - verif/bus_memory_checker.sv
      - verif/bus_memory_tb.sv
